// File: verilog/qtz_pkg.sv
package qtz_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    localparam int HV_DIM          = 512;
    localparam int SEG_WIDTH       = 32;
    localparam int SEQ_CYCLE_COUNT = HV_DIM / SEG_WIDTH;
    localparam int CTR_WIDTH       = $clog2(SEQ_CYCLE_COUNT);

    localparam logic [CTR_WIDTH-1:0] LAST_SEG = CTR_WIDTH'(SEQ_CYCLE_COUNT - 1);

    //////////////////////////////////////////////////////////////////////
    // Quantizer
    //////////////////////////////////////////////////////////////////////

    localparam int FEATURE_WIDTH = 16;
    localparam int LEVEL_BITS    = 4;
    localparam int LEVEL_COUNT   = 2 ** LEVEL_BITS;
    localparam int FLIP_STEP     = HV_DIM / (2 * LEVEL_COUNT);  // 16 bits per level step.

    localparam logic [SEG_WIDTH-1:0] BASE_SEED = 32'h9E37_79B9;

    typedef struct packed {
        logic [LEVEL_BITS-1:0]               level;
        logic [FEATURE_WIDTH-LEVEL_BITS-1:0] frac;
    } feature_fields_t;

    typedef union packed {
        logic [FEATURE_WIDTH-1:0] raw;
        feature_fields_t          fields;
    } feature_word_t;

    // Level L keeps the base vector except for global bits i < L*FLIP_STEP,
    // which are inverted. Bit i sits in segment i/32 at position i mod 32.
    // The base word of segment s is BASE_SEED rotated left by s.
    function automatic logic [SEG_WIDTH-1:0] base_segment(input logic [CTR_WIDTH-1:0] seg);
        return (BASE_SEED << seg) | (BASE_SEED >> (SEG_WIDTH - seg));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    localparam int AXI_ADDR_WIDTH = 8;
    localparam int AXI_DATA_WIDTH = 32;

    localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_CTRL    = 8'h00;
    localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_FEATURE = 8'h04;
    localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_STATUS  = 8'h08;
    localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_HV_BASE = 8'h40;
    localparam logic [AXI_ADDR_WIDTH-1:0] HV_ADDR_MASK = AXI_ADDR_WIDTH'(SEQ_CYCLE_COUNT * 4 - 1);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: verilog/qtz_map_if.sv
`timescale 1ns/1ps

interface qtz_map_if;

    logic                          start_mapping;
    logic                          en;
    logic [qtz_pkg::CTR_WIDTH-1:0] ctr;  // Segment select.
    logic                          mapping_hv_segment;
    logic                          mapping_done;

    modport fsm (
        input  start_mapping, en,
        output ctr, mapping_hv_segment, mapping_done
    );

    modport data (
        input  ctr, mapping_hv_segment, mapping_done, en
    );

    modport host (
        output start_mapping, en,
        input  mapping_done, mapping_hv_segment
    );

endinterface

// File: verilog/qtz_fsm.sv
`timescale 1ns/1ps

module qtz_fsm (
    input  logic   clk,
    input  logic   nrst,
    qtz_map_if.fsm map
);

    typedef enum logic [1:0] {S_IDLE, S_MAP, S_BUFFER, S_MAP_DONE} state_t;

    state_t state;
    logic   start_ok;
    logic   hv_fetch_done;

    assign start_ok      = map.start_mapping && map.en;
    assign hv_fetch_done = map.en && (map.ctr == qtz_pkg::LAST_SEG);  // Final segment written.

    //////////////////////////////////////////////////////////////////////
    // State transitions
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= S_IDLE;
        end
        else begin
            case (state)
                S_IDLE: begin
                    if (start_ok) begin
                        state <= S_MAP;
                    end
                end
                S_MAP: begin
                    if (hv_fetch_done) begin
                        state <= S_BUFFER;
                    end
                end
                S_BUFFER:   state <= S_MAP_DONE;  // Fill bank copied out here.
                S_MAP_DONE: begin
                    // Done holds until the next accepted start.
                    if (start_ok) begin
                        state <= S_MAP;
                    end
                end
                default:    state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state)
            S_MAP:      {map.mapping_hv_segment, map.mapping_done} = 2'b10;
            S_MAP_DONE: {map.mapping_hv_segment, map.mapping_done} = 2'b01;
            default:    {map.mapping_hv_segment, map.mapping_done} = 2'b00;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Segment counter
    //////////////////////////////////////////////////////////////////////

    // Dropping en clears the count, so the sequence restarts from 0.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            map.ctr <= '0;
        end
        else begin
            if ((state == S_MAP) && map.en) begin
                map.ctr <= map.ctr + 1'b1;  // Wraps to 0 after the last segment.
            end
            else begin
                map.ctr <= '0;
            end
        end
    end

endmodule

// File: verilog/qtz_level_memory.sv
`timescale 1ns/1ps

module qtz_level_memory (
    input  qtz_pkg::feature_word_t        feature,
    qtz_map_if.data                       map,
    output logic [qtz_pkg::SEG_WIDTH-1:0] segment
);

    logic [qtz_pkg::LEVEL_BITS-1:0] level;
    logic [qtz_pkg::SEG_WIDTH-1:0]  base_word;
    logic [qtz_pkg::SEG_WIDTH-1:0]  mask;

    // Marks the bits of one segment that fall below the flip limit.
    function automatic logic [qtz_pkg::SEG_WIDTH-1:0] flip_mask(
        input logic [qtz_pkg::LEVEL_BITS-1:0] lvl,
        input logic [qtz_pkg::CTR_WIDTH-1:0]  seg
    );
        int unsigned                   limit;
        int unsigned                   first;
        logic [qtz_pkg::SEG_WIDTH-1:0] m;

        limit = lvl * qtz_pkg::FLIP_STEP;
        first = seg * qtz_pkg::SEG_WIDTH;  // Global index of bit 0.
        for (int j = 0; j < qtz_pkg::SEG_WIDTH; j++) begin
            m[j] = ((first + j) < limit);
        end
        return m;
    endfunction

    // Quantization keeps the upper feature bits.
    assign level = feature.fields.level;

    assign base_word = qtz_pkg::base_segment(map.ctr);
    assign mask      = flip_mask(level, map.ctr);

    assign segment = base_word ^ mask;

endmodule

// File: verilog/qtz_hv_buffer.sv
`timescale 1ns/1ps

module qtz_hv_buffer (
    input  logic                          clk,
    input  logic                          nrst,
    qtz_map_if.data                       map,
    input  logic [qtz_pkg::SEG_WIDTH-1:0] segment,
    input  logic [qtz_pkg::CTR_WIDTH-1:0] rd_index,
    output logic [qtz_pkg::SEG_WIDTH-1:0] rd_word
);

    logic [qtz_pkg::SEG_WIDTH-1:0] fill_bank [qtz_pkg::SEQ_CYCLE_COUNT];
    logic [qtz_pkg::SEG_WIDTH-1:0] out_bank  [qtz_pkg::SEQ_CYCLE_COUNT];
    logic                          seg_write;
    logic                          last_seg;
    logic                          buffering;

    assign seg_write = map.mapping_hv_segment && map.en;
    assign last_seg  = seg_write && (map.ctr == qtz_pkg::LAST_SEG);

    //////////////////////////////////////////////////////////////////////
    // Fill bank
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fill_bank <= '{default: '0};
        end
        else if (seg_write) begin
            fill_bank[map.ctr] <= segment;  // Demux by segment counter.
        end
    end

    // High during the buffering cycle.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            buffering <= 1'b0;
        end
        else begin
            buffering <= last_seg;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output bank
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            out_bank <= '{default: '0};
        end
        else if (buffering) begin
            out_bank <= fill_bank;  // Visible when done rises.
        end
    end

    assign rd_word = out_bank[rd_index];

endmodule

// File: verilog/qtz_axil_regs.sv
`timescale 1ns/1ps

module qtz_axil_regs (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic [qtz_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [qtz_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [qtz_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [qtz_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready,
    qtz_map_if.host                            map,
    output qtz_pkg::feature_word_t             feature,
    output logic [qtz_pkg::CTR_WIDTH-1:0]      rd_index,
    input  logic [qtz_pkg::SEG_WIDTH-1:0]      rd_word
);

    logic                               wr_take;
    logic                               wr_fire;
    logic                               wr_hit;
    logic                               rd_take;
    logic                               rd_fire;
    logic                               rd_hit;
    logic [qtz_pkg::AXI_DATA_WIDTH-1:0] rd_value;
    logic                               ctrl_en;

    function automatic logic hv_hit(input logic [qtz_pkg::AXI_ADDR_WIDTH-1:0] addr);
        return (addr[1:0] == 2'b00) &&
               ((addr & ~qtz_pkg::HV_ADDR_MASK) == qtz_pkg::ADDR_HV_BASE);
    endfunction

    // Ready pulses only with no response pending.
    assign wr_take = awvalid && wvalid && !bvalid && !awready;
    assign wr_fire = awready && awvalid && wvalid;
    assign rd_take = arvalid && !rvalid && !arready;
    assign rd_fire = arready && arvalid;

    assign wr_hit = (awaddr == qtz_pkg::ADDR_CTRL) || (awaddr == qtz_pkg::ADDR_FEATURE) ||
                    (awaddr == qtz_pkg::ADDR_STATUS) || hv_hit(awaddr);

    assign map.en   = ctrl_en;
    assign rd_index = araddr[2 +: qtz_pkg::CTR_WIDTH];

    //////////////////////////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            awready           <= 1'b0;
            wready            <= 1'b0;
            bvalid            <= 1'b0;
            bresp             <= qtz_pkg::RESP_OKAY;
            map.start_mapping <= 1'b0;
            ctrl_en           <= 1'b0;
            feature.raw       <= '0;
        end
        else begin
            awready           <= wr_take;
            wready            <= wr_take;
            map.start_mapping <= 1'b0;  // One-cycle pulse.
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_hit ? qtz_pkg::RESP_OKAY : qtz_pkg::RESP_SLVERR;
                if (awaddr == qtz_pkg::ADDR_CTRL) begin
                    map.start_mapping <= wdata[0];
                    ctrl_en           <= wdata[1];
                end
                if (awaddr == qtz_pkg::ADDR_FEATURE) begin
                    feature.raw <= wdata[qtz_pkg::FEATURE_WIDTH-1:0];
                end
            end
            else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_value = '0;
        rd_hit   = 1'b1;
        if (araddr == qtz_pkg::ADDR_CTRL) begin
            rd_value[1] = ctrl_en;  // Start reads back as 0.
        end
        else if (araddr == qtz_pkg::ADDR_FEATURE) begin
            rd_value[qtz_pkg::FEATURE_WIDTH-1:0] = feature.raw;
            rd_value[16 +: qtz_pkg::LEVEL_BITS]  = feature.fields.level;
        end
        else if (araddr == qtz_pkg::ADDR_STATUS) begin
            rd_value[0] = map.mapping_done;
            rd_value[1] = map.mapping_hv_segment;
        end
        else if (hv_hit(araddr)) begin
            rd_value = rd_word;
        end
        else begin
            rd_hit = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= qtz_pkg::RESP_OKAY;
        end
        else begin
            arready <= rd_take;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_value;  // Held until rready.
                rresp  <= rd_hit ? qtz_pkg::RESP_OKAY : qtz_pkg::RESP_SLVERR;
            end
            else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/qtz_top.sv
`timescale 1ns/1ps

module qtz_top (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic [qtz_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [qtz_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [qtz_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [qtz_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready
);

    qtz_pkg::feature_word_t        feature;
    logic [qtz_pkg::SEG_WIDTH-1:0] segment;
    logic [qtz_pkg::CTR_WIDTH-1:0] rd_index;
    logic [qtz_pkg::SEG_WIDTH-1:0] rd_word;

    qtz_map_if map_bus ();

    qtz_fsm u_fsm (
        .clk  (clk),
        .nrst (nrst),
        .map  (map_bus.fsm)
    );

    qtz_level_memory u_level_memory (
        .feature (feature),
        .map     (map_bus.data),
        .segment (segment)
    );

    qtz_hv_buffer u_hv_buffer (
        .clk      (clk),
        .nrst     (nrst),
        .map      (map_bus.data),
        .segment  (segment),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

    // Host side register map.
    qtz_axil_regs u_axil_regs (
        .clk      (clk),
        .nrst     (nrst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .map      (map_bus.host),
        .feature  (feature),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

endmodule

// File: tb/qtz_axil_tasks.svh
`ifndef QTZ_AXIL_TASKS_SVH
`define QTZ_AXIL_TASKS_SVH

task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("** Error: %s = %h, expected %h", name, got, exp);
        $display("TEST FAILED");
        $fatal(1);
    end
endtask

// Segment seg of the level hypervector, built bit by bit.
function automatic logic [31:0] expected_word(input int level, input int seg);
    logic [31:0] w;
    w = qtz_pkg::BASE_SEED;
    for (int k = 0; k < seg; k++) begin
        w = {w[30:0], w[31]};  // Rotate left once.
    end
    for (int j = 0; j < 32; j++) begin
        if ((seg * 32 + j) < (level * qtz_pkg::FLIP_STEP)) begin
            w[j] = ~w[j];
        end
    end
    return w;
endfunction

// With hold > 0 bready stays low and a second write waits on the bus.
task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int hold,
                         output logic [1:0] resp);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b0;
    do @(posedge clk); while (!awready);
    check_equal("wready", wready, 1'b1);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk);
    check_equal("bvalid", bvalid, 1'b1);
    resp = bresp;
    repeat (hold) begin
        awaddr  <= qtz_pkg::ADDR_FEATURE;
        wdata   <= 32'h0000_DEAD;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge clk);
        check_equal("awready", awready, 1'b0);
        check_equal("wready", wready, 1'b0);
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    @(posedge clk);
    bready  <= 1'b0;
endtask

task automatic axi_read(input logic [7:0] addr, input int hold,
                        output logic [31:0] data, output logic [1:0] resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b0;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    @(posedge clk);
    check_equal("rvalid", rvalid, 1'b1);
    data = rdata;
    resp = rresp;
    repeat (hold) @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
endtask

`endif

// File: tb/tb_qtz_top.sv
`timescale 1ns/1ps

module tb_qtz_top;

    localparam int MAP_COUNT      = 8;
    localparam int MAP_CYCLES     = 40;
    localparam int ACCESS_COUNT   = 240;
    localparam int ACCESS_CYCLES  = 8;
    localparam int TIMEOUT_CYCLES = MAP_COUNT * MAP_CYCLES + ACCESS_COUNT * ACCESS_CYCLES;

    logic        clk;
    logic        nrst;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int          cycles;
    int          done_rises;
    logic        done_q;
    logic [31:0] rd;
    logic [1:0]  rs;
    int          rises_before;
    logic [15:0] features [4] = '{16'h0000, 16'h1234, 16'h8FFF, 16'hFFFF};

    qtz_top UUT (.*);

    `include "qtz_axil_tasks.svh"

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Protocol and FSM checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!nrst)
        !(UUT.map_bus.mapping_hv_segment && UUT.map_bus.mapping_done))
    else begin
        $display("** Error: mapping_hv_segment = %h with mapping_done = %h",
                 UUT.map_bus.mapping_hv_segment, UUT.map_bus.mapping_done);
        $display("TEST FAILED");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (!nrst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else begin
        $display("** Error: rdata = %h, rresp = %h changed while waiting", rdata, rresp);
        $display("TEST FAILED");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (!nrst)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else begin
        $display("** Error: bresp = %h, bvalid = %h changed while waiting", bresp, bvalid);
        $display("TEST FAILED");
        $fatal(1);
    end

    // Counts done rising edges and bounds the run.
    always @(posedge clk) begin
        done_q <= UUT.map_bus.mapping_done;
        if (UUT.map_bus.mapping_done && !done_q) begin
            done_rises <= done_rises + 1;
        end
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    task automatic wait_done();
        logic [31:0] d;
        logic [1:0]  r;
        do axi_read(qtz_pkg::ADDR_STATUS, 0, d, r); while (!d[0]);
    endtask

    task automatic check_hv(input int level);
        logic [31:0] d;
        logic [1:0]  r;
        for (int s = 0; s < 16; s++) begin
            axi_read(qtz_pkg::ADDR_HV_BASE + 8'(4 * s), 0, d, r);
            check_equal("rresp", r, qtz_pkg::RESP_OKAY);
            check_equal("rdata", d, expected_word(level, s));
        end
    endtask

    initial begin
        clk        = 0;
        nrst       = 0;
        awaddr     = 0;
        awvalid    = 0;
        wdata      = 0;
        wvalid     = 0;
        bready     = 0;
        araddr     = 0;
        arvalid    = 0;
        rready     = 0;
        cycles     = 0;
        done_rises = 0;
        done_q     = 0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_equal("ready_valid", {awready, wready, bvalid, arready, rvalid}, 0);
        end
        axi_read(qtz_pkg::ADDR_STATUS, 0, rd, rs);
        check_equal("status", rd, 0);
        // Both banks come out of reset cleared.
        for (int s = 0; s < 16; s++) begin
            axi_read(qtz_pkg::ADDR_HV_BASE + 8'(4 * s), 0, rd, rs);
            check_equal("rresp", rs, qtz_pkg::RESP_OKAY);
            check_equal("rdata", rd, 0);
        end
        for (int k = 0; k < 4; k++) begin
            axi_write(qtz_pkg::ADDR_FEATURE, {16'h0, features[k]}, 0, rs);
            axi_write(qtz_pkg::ADDR_CTRL, 32'h3, 0, rs);
            check_equal("bresp", rs, qtz_pkg::RESP_OKAY);
            wait_done();
            axi_read(qtz_pkg::ADDR_FEATURE, 0, rd, rs);
            check_equal("feature", rd, {12'h0, features[k][15:12], features[k]});
            check_hv(features[k] >> 12);
        end
        // Reads during mapping return the previous vector.
        axi_write(qtz_pkg::ADDR_FEATURE, 32'h5000, 0, rs);
        axi_write(qtz_pkg::ADDR_CTRL, 32'h3, 0, rs);
        axi_read(qtz_pkg::ADDR_HV_BASE + 8'h0C, 0, rd, rs);
        check_equal("rdata", rd, expected_word(15, 3));
        wait_done();
        check_hv(5);
        // Start during mapping is ignored.
        axi_write(qtz_pkg::ADDR_FEATURE, 32'hA123, 0, rs);
        rises_before = done_rises;
        axi_write(qtz_pkg::ADDR_CTRL, 32'h3, 0, rs);
        do axi_read(qtz_pkg::ADDR_STATUS, 0, rd, rs); while (!rd[1]);
        axi_write(qtz_pkg::ADDR_CTRL, 32'h3, 0, rs);
        wait_done();
        repeat (30) @(posedge clk);
        check_equal("done_rises", done_rises, rises_before + 1);
        check_hv(10);
        // Dropping en stalls the mapping.
        axi_write(qtz_pkg::ADDR_FEATURE, 32'h3ABC, 0, rs);
        rises_before = done_rises;
        axi_write(qtz_pkg::ADDR_CTRL, 32'h3, 0, rs);
        axi_write(qtz_pkg::ADDR_CTRL, 32'h0, 0, rs);
        repeat (40) @(posedge clk);
        axi_read(qtz_pkg::ADDR_STATUS, 0, rd, rs);
        check_equal("status", rd, 32'h2);
        check_equal("done_rises", done_rises, rises_before);
        axi_write(qtz_pkg::ADDR_CTRL, 32'h2, 0, rs);
        wait_done();
        check_hv(3);
        // Unmapped address, with back-pressure on both channels.
        axi_write(8'h20, 32'h1234_5678, 3, rs);
        check_equal("bresp", rs, qtz_pkg::RESP_SLVERR);
        axi_read(qtz_pkg::ADDR_FEATURE, 0, rd, rs);
        check_equal("feature", rd, 32'h0003_3ABC);
        axi_read(8'h20, 3, rd, rs);
        check_equal("rresp", rs, qtz_pkg::RESP_SLVERR);
        check_equal("rdata", rd, 0);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+tb
verilog/qtz_pkg.sv
verilog/qtz_map_if.sv
verilog/qtz_fsm.sv
verilog/qtz_level_memory.sv
verilog/qtz_hv_buffer.sv
verilog/qtz_axil_regs.sv
verilog/qtz_top.sv
tb/tb_qtz_top.sv
